//--- lock_config.svh
`ifndef LOCK_CONFIG_SVH
`define LOCK_CONFIG_SVH

// password and display words, three bcd nibbles
`define LOCK_PASSWORD       12'h246
`define LOCK_PASS_PATTERN   12'hBCC
`define LOCK_IDLE_DISPLAY   12'hFFF

// failed tries before lockout, fits the 3-bit counter
`define LOCK_MAX_TRIES      3'd6

// tone timing in clock cycles, short for simulation
`define TONE_CLICK_HALF      4   // board 50000
`define TONE_CLICK_LEN       40  // board 10000000
`define TONE_SUCCESS_HALF    2   // board 25000
`define TONE_SUCCESS_LEN     60  // board 30000000
`define TONE_FAIL_HALF       8   // board 100000
`define TONE_FAIL_LEN        90  // board 15000000

// silent stretch inside the failure tone
`define TONE_FAIL_GAP_START  30  // board 5000000
`define TONE_FAIL_GAP_END    60  // board 10000000

`endif

//--- lock_pkg.sv
package lock_pkg;

    typedef enum logic {
        KEY_DIGIT = 1'b0,
        KEY_CMD   = 1'b1
    } key_kind_e;

    typedef enum logic [3:0] {
        CMD_ENTER = 4'd0,  // submit the code
        CMD_CLEAR = 4'd1,  // drop current entry
        CMD_ADMIN = 4'd2   // clear tries and lockout
    } lock_cmd_e;

    // one key event word, kind bit selects the view
    typedef union packed {
        struct packed {
            key_kind_e  kind;
            logic [3:0] value;  // bcd digit 0..9
        } dig;
        struct packed {
            key_kind_e kind;
            lock_cmd_e cmd;
        } cmd;
    } key_event_u;

    typedef enum logic [1:0] {
        TONE_NONE    = 2'd0,
        TONE_CLICK   = 2'd1,
        TONE_SUCCESS = 2'd2,
        TONE_FAIL    = 2'd3
    } tone_e;

endpackage

//--- key_decoder.sv
`timescale 1ns/1ps

module key_decoder import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [15:0] keys,
    output logic       key_valid,
    output key_event_u key_event
);

    logic [15:0] keys_q;     // registered key vector
    logic [15:0] keys_prev;  // vector one cycle earlier
    logic        map_valid;
    key_event_u  map_event;

    // board layout, exact one-hot values only
    always_comb begin
        map_valid = 1'b1;
        map_event = '0;
        map_event.dig.kind = KEY_DIGIT;
        case (keys_q)
            16'h0008: map_event.dig.value = 4'd0;
            16'h0080: map_event.dig.value = 4'd1;
            16'h0040: map_event.dig.value = 4'd2;
            16'h0020: map_event.dig.value = 4'd3;
            16'h0800: map_event.dig.value = 4'd4;
            16'h0400: map_event.dig.value = 4'd5;
            16'h0200: map_event.dig.value = 4'd6;
            16'h8000: map_event.dig.value = 4'd7;
            16'h4000: map_event.dig.value = 4'd8;
            16'h2000: map_event.dig.value = 4'd9;
            16'h0001: begin
                map_event.cmd.kind = KEY_CMD;
                map_event.cmd.cmd  = CMD_ENTER;
            end
            16'h1000: begin
                map_event.cmd.kind = KEY_CMD;
                map_event.cmd.cmd  = CMD_CLEAR;
            end
            16'h0100: begin
                map_event.cmd.kind = KEY_CMD;
                map_event.cmd.cmd  = CMD_ADMIN;
            end
            default: map_valid = 1'b0;  // unmapped or several keys
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_q    <= '0;
            keys_prev <= '0;
            key_valid <= 1'b0;
        end else begin
            keys_q    <= keys;
            keys_prev <= keys_q;
            key_valid <= map_valid && (keys_prev == '0);  // press edge only
        end
    end

    always_ff @(posedge clk) begin
        key_event <= map_event;
    end

endmodule

//--- code_lock.sv
`timescale 1ns/1ps
`include "lock_config.svh"

module code_lock import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid,
    input  key_event_u key_event,
    output logic [11:0] display,
    output logic [2:0] tries,
    output logic       unlocked,
    output logic       locked,
    output logic       tone_start,
    output tone_e      tone_kind
);

    logic [1:0]  digit_cnt;   // digits entered so far
    logic [2:0]  tries_next;
    logic        entry_open;  // digits and enter accepted
    logic [11:0] shifted;

    assign tries_next = tries + 3'd1;
    assign entry_open = !locked && !unlocked;

    // first digit on an idle display clears the upper nibbles
    assign shifted = (display == `LOCK_IDLE_DISPLAY) ?
                     {8'h00, key_event.dig.value} :
                     {display[7:0], key_event.dig.value};

    always_ff @(posedge clk) begin
        if (rst) begin
            display    <= `LOCK_IDLE_DISPLAY;
            tries      <= '0;
            unlocked   <= 1'b0;
            locked     <= 1'b0;
            digit_cnt  <= '0;
            tone_start <= 1'b0;
            tone_kind  <= TONE_NONE;
        end else begin
            tone_start <= 1'b0;
            if (key_valid) begin
                if (key_event.dig.kind == KEY_DIGIT) begin
                    if (entry_open && digit_cnt < 2'd3) begin
                        display    <= shifted;
                        digit_cnt  <= digit_cnt + 2'd1;
                        tone_start <= 1'b1;
                        tone_kind  <= TONE_CLICK;
                    end
                end else begin
                    case (key_event.cmd.cmd)
                        CMD_ADMIN: begin  // works even when locked
                            display   <= `LOCK_IDLE_DISPLAY;
                            digit_cnt <= '0;
                            tries     <= '0;
                            locked    <= 1'b0;
                            unlocked  <= 1'b0;
                        end
                        CMD_CLEAR: begin
                            if (!locked) begin
                                display   <= `LOCK_IDLE_DISPLAY;
                                digit_cnt <= '0;
                                unlocked  <= 1'b0;  // tries kept
                            end
                        end
                        CMD_ENTER: begin
                            if (entry_open && digit_cnt == 2'd3) begin
                                tone_start <= 1'b1;
                                if (display == `LOCK_PASSWORD) begin
                                    display   <= `LOCK_PASS_PATTERN;
                                    unlocked  <= 1'b1;
                                    tone_kind <= TONE_SUCCESS;
                                end else begin
                                    tries     <= tries_next;
                                    digit_cnt <= '0;
                                    tone_kind <= TONE_FAIL;
                                    if (tries_next == `LOCK_MAX_TRIES) begin
                                        display <= '0;  // lockout shows zeros
                                        locked  <= 1'b1;
                                    end else begin
                                        display <= `LOCK_IDLE_DISPLAY;
                                    end
                                end
                            end
                        end
                        default: ;  // unknown command code
                    endcase
                end
            end
        end
    end

endmodule

//--- tone_generator.sv
`timescale 1ns/1ps
`include "lock_config.svh"

module tone_generator import lock_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  tone_start,
    input  tone_e tone_kind,
    output logic  buzzer
);

    tone_e       active;    // pattern being played
    logic [15:0] dur_cnt;   // cycles since tone_start
    logic [15:0] half_cnt;  // cycles since last toggle
    logic [15:0] half_lim;
    logic [15:0] len;
    logic        in_gap;

    always_comb begin
        case (active)
            TONE_CLICK: begin
                half_lim = 16'(`TONE_CLICK_HALF);
                len      = 16'(`TONE_CLICK_LEN);
            end
            TONE_SUCCESS: begin
                half_lim = 16'(`TONE_SUCCESS_HALF);
                len      = 16'(`TONE_SUCCESS_LEN);
            end
            TONE_FAIL: begin
                half_lim = 16'(`TONE_FAIL_HALF);
                len      = 16'(`TONE_FAIL_LEN);
            end
            default: begin
                half_lim = '0;
                len      = '0;
            end
        endcase
    end

    // broken failure tone, silent in the middle
    assign in_gap = (active == TONE_FAIL) &&
                    (dur_cnt >= 16'(`TONE_FAIL_GAP_START)) &&
                    (dur_cnt < 16'(`TONE_FAIL_GAP_END));

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= TONE_NONE;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (tone_start) begin  // restart whatever plays
            active   <= tone_kind;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= (tone_kind != TONE_NONE);
        end else if (active != TONE_NONE) begin
            dur_cnt <= dur_cnt + 16'd1;
            if (half_cnt >= half_lim) begin
                half_cnt <= '0;
                buzzer   <= ~buzzer;
            end else begin
                half_cnt <= half_cnt + 16'd1;
            end
            if (in_gap)
                buzzer <= 1'b0;
            if (dur_cnt >= len) begin  // pattern done
                active <= TONE_NONE;
                buzzer <= 1'b0;
            end
        end else begin
            buzzer <= 1'b0;
        end
    end

endmodule

//--- lock_top.sv
`timescale 1ns/1ps

module lock_top import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] keys,
    output logic [11:0] display,
    output logic [2:0]  tries,
    output logic        unlocked,
    output logic        locked,
    output logic        buzzer
);

    logic       key_valid;
    key_event_u key_event;
    logic       tone_start;
    tone_e      tone_kind;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_valid (key_valid),
        .key_event (key_event)
    );

    code_lock u_code_lock (
        .clk        (clk),
        .rst        (rst),
        .key_valid  (key_valid),
        .key_event  (key_event),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked     (locked),
        .tone_start (tone_start),
        .tone_kind  (tone_kind)
    );

    tone_generator u_tone_generator (
        .clk        (clk),
        .rst        (rst),
        .tone_start (tone_start),
        .tone_kind  (tone_kind),
        .buzzer     (buzzer)
    );

endmodule

//--- tb_lock_top.sv
`timescale 1ns/1ps
`include "lock_config.svh"

module tb_lock_top;

    localparam int HOLD_CYCLES = 4;  // key held down this long
    localparam int TONE_LAT    = 3;  // key change to tone_start edge
    // runs past the pattern end by more than one full tone period
    localparam int FAIL_WATCH  = TONE_LAT + `TONE_FAIL_LEN + 3 + 4 * `TONE_FAIL_HALF;

    logic        clk;
    logic        rst;
    logic [15:0] keys;
    logic [11:0] display;
    logic [2:0]  tries;
    logic        unlocked;
    logic        locked;
    logic        buzzer;

    integer seed;
    integer errors;
    integer checks;

    lock_top UUT (
        .clk      (clk),
        .rst      (rst),
        .keys     (keys),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .locked   (locked),
        .buzzer   (buzzer)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // press, hold and release one key and watch the buzzer if asked
    // mode 0 no buzzer check, 1 click, 2 failure pattern
    task automatic press_key(input string name, input logic [15:0] key_vec, input int mode);
        int c;
        int m;
        bit seen;
        bit timed_out;
        c         = 0;
        seen      = 1'b0;
        timed_out = 1'b0;
        if (mode == 1)
            check_value({name, " buzzer idle"}, 16'd0, {15'd0, buzzer});
        keys = key_vec;
        while (c < HOLD_CYCLES || (mode == 1 && !seen && !timed_out) ||
               (mode == 2 && c < FAIL_WATCH)) begin
            @(negedge clk);
            c = c + 1;
            m = c - TONE_LAT;  // cycles since tone_start
            if (c == HOLD_CYCLES)
                keys = '0;
            if (mode == 1 && m >= 1 && buzzer)
                seen = 1'b1;
            if (mode == 1 && !seen && m >= `TONE_CLICK_HALF + 3) begin
                $display("timeout in %s: buzzer never went high for the click", name);
                errors    = errors + 1;
                timed_out = 1'b1;
            end
            if (mode == 2 && ((m >= `TONE_FAIL_GAP_START + 3 && m <= `TONE_FAIL_GAP_END) ||
                              m >= `TONE_FAIL_LEN + 3))
                check_value({name, " buzzer silent"}, 16'd0, {15'd0, buzzer});
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          mode;
        string       line;
        string       name;
        logic [15:0] key_vec;
        logic [15:0] exp_display;
        logic [15:0] exp_tries;
        logic [15:0] exp_unlocked;
        logic [15:0] exp_locked;

        clk    = 1'b0;
        rst    = 1'b1;
        keys   = '0;
        seed   = 66560;
        errors = 0;
        checks = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("reset display", 16'hFFF, {4'd0, display});
        check_value("reset tries", 16'd0, {13'd0, tries});
        check_value("reset unlocked", 16'd0, {15'd0, unlocked});
        check_value("reset locked", 16'd0, {15'd0, locked});
        check_value("reset buzzer", 16'd0, {15'd0, buzzer});

        fd = $fopen("lock_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open lock_testdata.txt for reading");
            errors = errors + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %d", name, key_vec, exp_display,
                                exp_tries, exp_unlocked, exp_locked, mode);
                    if (n > 0 && n != 7) begin
                        $display("malformed line in the data file: %s", line);
                        errors = errors + 1;
                    end
                    if (n == 7) begin
                        press_key(name, key_vec, mode);
                        gap = 2 + ($unsigned($random(seed)) % 8);  // release gap 2..9
                        repeat (gap) @(negedge clk);
                        check_value({name, " display"}, exp_display, {4'd0, display});
                        check_value({name, " tries"}, exp_tries, {13'd0, tries});
                        check_value({name, " unlocked"}, exp_unlocked, {15'd0, unlocked});
                        check_value({name, " locked"}, exp_locked, {15'd0, locked});
                    end
                end
            end
            $fclose(fd);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- lock_testdata.txt
# name keys display tries unlocked locked buzzer_check
# all values hex except buzzer_check: 0 none, 1 click, 2 failure pattern
digit_2 0040 002 0 0 0 1
digit_4 0800 024 0 0 0 0
unmapped_key 0002 024 0 0 0 0
multi_key 0840 024 0 0 0 0
repeat_4 0800 244 0 0 0 0
fourth_digit 0200 244 0 0 0 0
wrong_244 0001 FFF 1 0 0 2
code_2 0040 002 1 0 0 1
code_4 0800 024 1 0 0 0
code_6 0200 246 1 0 0 0
enter_good 0001 BCC 1 1 0 0
digit_unlocked 0400 BCC 1 1 0 0
clear_unlocked 1000 FFF 1 0 0 0
short_1 0080 001 1 0 0 0
short_2 0040 012 1 0 0 0
short_enter 0001 012 1 0 0 0
short_3 0020 123 1 0 0 0
wrong_123 0001 FFF 2 0 0 0
try3_1 0080 001 2 0 0 0
try3_3 0020 013 2 0 0 0
try3_5 0400 135 2 0 0 0
wrong_135 0001 FFF 3 0 0 0
try4_7a 8000 007 3 0 0 0
try4_7b 8000 077 3 0 0 0
try4_7c 8000 777 3 0 0 0
wrong_777 0001 FFF 4 0 0 0
try5_9 2000 009 4 0 0 0
try5_0 0008 090 4 0 0 0
try5_8 4000 908 4 0 0 0
wrong_908 0001 FFF 5 0 0 0
try6_0a 0008 000 5 0 0 0
try6_0b 0008 000 5 0 0 0
try6_0c 0008 000 5 0 0 0
lockout 0001 000 6 0 1 0
locked_digit 0040 000 6 0 1 0
locked_enter 0001 000 6 0 1 0
locked_clear 1000 000 6 0 1 0
admin_reset 0100 FFF 0 0 0 0
after_admin 0800 004 0 0 0 0

//--- build.f
+incdir+.
lock_pkg.sv
key_decoder.sv
code_lock.sv
tone_generator.sv
lock_top.sv
tb_lock_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_lock_top -Mdir obj_dir

out=$(./obj_dir/Vtb_lock_top)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
